// ==== flist.f ====
+incdir+hw
hw/pipe_pkg.sv
hw/inst_decoder.sv
hw/pipe_reg.sv
hw/bus_txn_fsm.sv
hw/fetch_stage.sv
hw/mem_stage.sv
hw/retire_counter.sv
hw/pipe_top.sv
tests/pipe_chk.sv
tests/pipe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pipe_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# Pass only if the log holds the pass line
run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG); grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/pipe_tb.sv ====
// Testbench for pipe_top with two programs walked from one table
// Program words sit below PROG_BYTES and loads above return addr ^ DATA_KEY
// Random acceptance refusals and data latency of 1 to 4 cycles, one txn at a time
`timescale 1ns/1ps
`include "pipe_params.svh"

module pipe_tb;
  import pipe_pkg::*;

  localparam int    TABLE_LEN   = 11;
  localparam int    PROG_WORDS  = 8;                    // 16 instructions max
  localparam int    PROG_BYTES  = PROG_WORDS * 8;
  localparam int    CLK_PERIOD  = 40;
  localparam int    WATCHDOG_NS = TABLE_LEN * 40 * CLK_PERIOD;
  localparam int    IDLE_CYCLES = 20;                   // Quiet window after a halt
  localparam word_t DATA_KEY    = 64'h5a5a_c3c3_0f0f_9696;
  localparam int    SEED        = 32'h7212;

  logic     clock;
  logic     reset;
  tag_t     mem_response;
  tag_t     mem_tag;
  word_t    mem_data;
  bus_cmd_t proc2mem_command;
  word_t    proc2mem_addr;
  logic     commit_valid;
  word_t    commit_npc;
  logic     commit_wr_en;
  reg_idx_t commit_wr_idx;
  word_t    commit_wr_data;
  error_t   error_status;
  logic [15:0] retired_count;

  // Program and expected commits
  string    t_name [TABLE_LEN];
  inst_t    t_inst [TABLE_LEN];
  logic     t_wr_en [TABLE_LEN];
  reg_idx_t t_idx [TABLE_LEN];
  word_t    t_data [TABLE_LEN];
  int       fill_idx = 0;

  word_t prog_mem [PROG_WORDS];
  int    error_count = 0;
  int    tests_run = 0;

  pipe_top i_pipe_top (.*);

  initial
  begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the DUT stopped committing before the table was done");
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Memory model
  logic  pending = 1'b0;
  tag_t  pend_tag;
  word_t pend_addr;
  int    wait_cnt;
  tag_t  next_tag = 4'd1;

  function automatic word_t read_word(input word_t addr);
    if (addr < word_t'(PROG_BYTES))
      return prog_mem[addr[5:3]];
    return addr ^ DATA_KEY;                             // Data rule
  endfunction

  initial
  begin
    mem_response = '0;
    mem_tag      = '0;
    mem_data     = '0;
    void'($urandom(SEED));
    forever
    begin
      @(posedge clock);
      #2;
      mem_response = '0;
      mem_tag      = '0;
      mem_data     = '0;
      if (reset)
        pending = 1'b0;
      else
      begin
        if (pending && wait_cnt == 0)                   // Data return cycle
        begin
          mem_tag  = pend_tag;
          mem_data = read_word(pend_addr);
          pending  = 1'b0;
        end
        else if (pending)
          wait_cnt = wait_cnt - 1;
        if (proc2mem_command == BUS_LOAD && !pending && ($urandom % 4) != 0)
        begin
          mem_response = next_tag;                      // Accept
          pend_tag     = next_tag;
          pend_addr    = proc2mem_addr;
          wait_cnt     = int'($urandom % 4);
          pending      = 1'b1;
          next_tag     = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
      error_count++;
      $display("error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (exp !== act)
    begin
      error_count++;
      $display("error: %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      error_count++;
      $display("error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input error_t exp, input error_t act);
    if (exp !== act)
    begin
      error_count++;
      $display("error: %s expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d mismatches", name, error_count - errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Table and program setup
  function automatic inst_t ldq_inst(input reg_idx_t ra, input logic [15:0] disp);
    return {`PIPE_OP_LDQ, ra, 5'd31, disp};             // Rb unused
  endfunction

  task automatic add_entry(input string name, input inst_t inst, input logic wr_en,
                           input reg_idx_t idx, input word_t data);
    t_name[fill_idx]  = name;
    t_inst[fill_idx]  = inst;
    t_wr_en[fill_idx] = wr_en;
    t_idx[fill_idx]   = idx;
    t_data[fill_idx]  = data;
    fill_idx++;
  endtask

  task automatic build_table();
    // Program A in entries 0..7
    add_entry("nop0", `PIPE_NOOP_INST, 1'b0, 5'd31, '0);
    add_entry("ldq r1", ldq_inst(5'd1, 16'h1008), 1'b1, 5'd1, 64'h1008 ^ DATA_KEY);
    add_entry("nop2", `PIPE_NOOP_INST, 1'b0, 5'd31, '0);
    add_entry("ldq r2", ldq_inst(5'd2, 16'h2010), 1'b1, 5'd2, 64'h2010 ^ DATA_KEY);
    add_entry("ldq r31", ldq_inst(5'd31, 16'h1100), 1'b0, 5'd31, '0);
    add_entry("ldq r7", ldq_inst(5'd7, 16'h3ff8), 1'b1, 5'd7, 64'h3ff8 ^ DATA_KEY);
    add_entry("nop6", `PIPE_NOOP_INST, 1'b0, 5'd31, '0);
    add_entry("halt", 32'h0000_0000, 1'b0, 5'd0, '0);
    // Program B in entries 8..10
    add_entry("nop8", `PIPE_NOOP_INST, 1'b0, 5'd31, '0);
    add_entry("ldq r3", ldq_inst(5'd3, 16'h1238), 1'b1, 5'd3, 64'h1238 ^ DATA_KEY);
    add_entry("illegal", 32'hfc00_0000, 1'b0, 5'd0, '0);
  endtask

  task automatic load_program(input int first, input int last);
    int j;
    for (int w = 0; w < PROG_WORDS; w++)
      prog_mem[w] = 64'(w * 8) ^ DATA_KEY;              // Fill pattern for unused slots
    for (int i = first; i <= last; i++)
    begin
      j = i - first;
      if (j % 2 == 0)
        prog_mem[3'(j / 2)][31:0] = t_inst[i];          // Lower half for an even slot
      else
        prog_mem[3'(j / 2)][63:32] = t_inst[i];
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #2 reset = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // One program from reset to its stopping instruction
  task automatic run_program(input int first, input int last, input error_t exp_status);
    int errs;
    load_program(first, last);
    apply_reset();
    errs = error_count;
    check_bit("reset commit_valid", 1'b0, commit_valid);
    check_bit("reset bus idle", 1'b1, proc2mem_command == BUS_NONE);
    check_status("reset status", NO_ERROR, error_status);
    check_word("reset count", '0, word_t'(retired_count));
    report_test("reset state", errs);
    for (int i = first; i <= last; i++)
    begin
      do
      begin
        @(posedge clock);
        #1;
      end
      while (!commit_valid);
      errs = error_count;
      check_word({t_name[i], " npc"}, 64'((i - first + 1) * `PIPE_INST_BYTES), commit_npc);
      check_bit({t_name[i], " wr_en"}, t_wr_en[i], commit_wr_en);
      check_idx({t_name[i], " idx"}, t_idx[i], commit_wr_idx);
      if (t_wr_en[i])
        check_word({t_name[i], " data"}, t_data[i], commit_wr_data);
      report_test(t_name[i], errs);
    end
    @(posedge clock);                                   // Status latches here
    #1;
    errs = error_count;
    check_status("final status", exp_status, error_status);
    check_word("retired count", 64'(last - first + 1), word_t'(retired_count));
    repeat (IDLE_CYCLES)
    begin
      @(posedge clock);
      #1;
      check_bit("bus idle after stop", 1'b1, proc2mem_command == BUS_NONE);
      check_bit("no commit after stop", 1'b0, commit_valid);
    end
    report_test("stop status", errs);
  endtask

  initial
  begin
    reset = 1'b1;
    build_table();
    run_program(0, 7, HALTED_ON_HALT);
    run_program(8, 10, HALTED_ON_ILLEGAL);              // Second reset inside
    error_count += i_pipe_top.i_pipe_chk.assert_failures;
    $display("tests %0d, errors %0d", tests_run, error_count);
    if (error_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== tests/pipe_chk.sv ====
// Bus and commit rules checked on the pipe_top ports by bind
// All rules but the reset one are off while reset is high
`timescale 1ns/1ps
`include "pipe_params.svh"

module pipe_chk (
  input logic                clock,
  input logic                reset,
  input pipe_pkg::bus_cmd_t  proc2mem_command,
  input pipe_pkg::word_t     proc2mem_addr,
  input logic                commit_valid,
  input logic                commit_wr_en,
  input pipe_pkg::reg_idx_t  commit_wr_idx
);
  import pipe_pkg::*;

  int assert_failures = 0;

  // Bus quiet in the first cycle out of reset
  a_idle_after_reset: assert property (@(posedge clock)
    $past(reset) |-> proc2mem_command == BUS_NONE)
    else begin assert_failures++; $error("bus command active right after reset"); end

  a_addr_aligned: assert property (@(posedge clock) disable iff (reset)
    proc2mem_command != BUS_NONE |-> proc2mem_addr[2:0] == 3'b000)
    else begin assert_failures++; $error("bus address not 8-byte aligned"); end

  a_wr_en_legal: assert property (@(posedge clock) disable iff (reset)
    commit_wr_en |-> commit_valid && commit_wr_idx != `PIPE_ZERO_REG)
    else begin assert_failures++; $error("write enable without valid or to r31"); end

endmodule

bind pipe_top pipe_chk i_pipe_chk (
  .clock(clock), .reset(reset),
  .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
  .commit_valid(commit_valid), .commit_wr_en(commit_wr_en),
  .commit_wr_idx(commit_wr_idx)
);

// ==== hw/pipe_top.sv ====
// Reduced in-order pipeline on one split-transaction memory bus
// Stages IF, ID, MEM, WB; no register file, no stores, no branches
// Data side wins the bus; only one instruction is in flight
`timescale 1ns/1ps

module pipe_top (
  input  logic                clock,
  input  logic                reset,
  input  pipe_pkg::tag_t      mem_response,
  input  pipe_pkg::tag_t      mem_tag,
  input  pipe_pkg::word_t     mem_data,
  output pipe_pkg::bus_cmd_t  proc2mem_command,
  output pipe_pkg::word_t     proc2mem_addr,
  output logic                commit_valid,
  output pipe_pkg::word_t     commit_npc,
  output logic                commit_wr_en,
  output pipe_pkg::reg_idx_t  commit_wr_idx,
  output pipe_pkg::word_t     commit_wr_data,
  output pipe_pkg::error_t    error_status,
  output logic [15:0]         retired_count
);
  import pipe_pkg::*;

  bus_cmd_t fetch_cmd;
  bus_cmd_t mem_cmd;
  word_t    fetch_addr;
  word_t    mem_addr;
  tag_t     fetch_resp;
  tag_t     mem_resp;
  logic     fetch_valid;
  fetch_t   fetch;
  logic     if_id_valid;
  fetch_t   if_id;
  decoded_t id_out;
  logic     id_mem_valid;
  decoded_t id_mem;
  logic     mem_stall;
  logic     mem_out_valid;
  retire_t  mem_out;
  logic     mem_wb_valid;
  retire_t  mem_wb;
  logic     halted;

  ////////////////////////////////////////////////////////////
  // Bus arbiter, data side first
  assign proc2mem_command = (mem_cmd != BUS_NONE) ? mem_cmd : fetch_cmd;
  assign proc2mem_addr    = (mem_cmd != BUS_NONE) ? mem_addr : fetch_addr;
  assign mem_resp   = (mem_cmd != BUS_NONE) ? mem_response : '0;  // Winner only
  assign fetch_resp = (mem_cmd == BUS_NONE) ? mem_response : '0;

  ////////////////////////////////////////////////////////////
  // IF and IF/ID
  fetch_stage i_fetch_stage (
    .clock(clock), .reset(reset), .retire(mem_wb_valid), .halted(halted),
    .mem_response(fetch_resp), .mem_tag(mem_tag), .mem_data(mem_data),
    .command(fetch_cmd), .bus_addr(fetch_addr),
    .fetch_valid(fetch_valid), .fetch(fetch)
  );

  pipe_reg #(.payload_t(fetch_t)) i_if_id (
    .clock(clock), .reset(reset), .enable(1'b1),  // Never has to hold
    .valid_in(fetch_valid), .data_in(fetch),
    .valid_out(if_id_valid), .data_out(if_id)
  );

  ////////////////////////////////////////////////////////////
  // ID and ID/MEM
  inst_decoder i_inst_decoder (
    .inst(if_id.inst), .inst_valid(if_id_valid),
    .load(id_out.load), .halt(id_out.halt), .illegal(id_out.illegal),
    .dest_idx(id_out.dest), .load_addr(id_out.load_addr)
  );
  assign id_out.npc = if_id.npc;

  pipe_reg #(.payload_t(decoded_t)) i_id_mem (
    .clock(clock), .reset(reset), .enable(~mem_stall),  // Back-pressure
    .valid_in(if_id_valid), .data_in(id_out),
    .valid_out(id_mem_valid), .data_out(id_mem)
  );

  ////////////////////////////////////////////////////////////
  // MEM and MEM/WB
  mem_stage i_mem_stage (
    .clock(clock), .reset(reset), .in_valid(id_mem_valid), .in(id_mem),
    .mem_response(mem_resp), .mem_tag(mem_tag), .mem_data(mem_data),
    .command(mem_cmd), .bus_addr(mem_addr), .stall(mem_stall),
    .out_valid(mem_out_valid), .out(mem_out)
  );

  pipe_reg #(.payload_t(retire_t)) i_mem_wb (
    .clock(clock), .reset(reset), .enable(1'b1),
    .valid_in(mem_out_valid), .data_in(mem_out),
    .valid_out(mem_wb_valid), .data_out(mem_wb)
  );

  ////////////////////////////////////////////////////////////
  // WB, commit and status
  retire_counter i_retire_counter (
    .clock(clock), .reset(reset), .retire(mem_wb_valid),
    .retire_halt(mem_wb.halt), .retire_illegal(mem_wb.illegal),
    .retired_count(retired_count), .error_status(error_status), .halted(halted)
  );

  assign commit_valid   = mem_wb_valid;
  assign commit_npc     = mem_wb.npc;
  assign commit_wr_en   = mem_wb.wr_en;     // Already qualified by valid
  assign commit_wr_idx  = mem_wb.dest;
  assign commit_wr_data = mem_wb.wr_data;

endmodule

// ==== hw/retire_counter.sv ====
// Retire count and halt status
// First halt or illegal instruction sets the status, later ones are ignored
// Count wraps at 16 bits
`timescale 1ns/1ps

module retire_counter (
  input  logic              clock,
  input  logic              reset,
  input  logic              retire,
  input  logic              retire_halt,
  input  logic              retire_illegal,
  output logic [15:0]       retired_count,
  output pipe_pkg::error_t  error_status,
  output logic              halted
);
  import pipe_pkg::*;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      retired_count <= '0;
      error_status  <= NO_ERROR;
    end
    else if (retire)
    begin
      retired_count <= retired_count + 16'd1;
      if (error_status == NO_ERROR)           // Keep the first cause
      begin
        if (retire_illegal)
          error_status <= HALTED_ON_ILLEGAL;  // Wins over halt
        else if (retire_halt)
          error_status <= HALTED_ON_HALT;
      end
    end
  end

  assign halted = (error_status != NO_ERROR);

endmodule

// ==== hw/mem_stage.sv ====
// Memory stage, executes loads over the bus
// Stall holds ID/MEM from the load's arrival until its done cycle
// Non-loads pass straight through with write enable low
`timescale 1ns/1ps
`include "pipe_params.svh"

module mem_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               in_valid,
  input  pipe_pkg::decoded_t in,
  input  pipe_pkg::tag_t     mem_response,
  input  pipe_pkg::tag_t     mem_tag,
  input  pipe_pkg::word_t    mem_data,
  output pipe_pkg::bus_cmd_t command,
  output pipe_pkg::word_t    bus_addr,
  output logic               stall,
  output logic               out_valid,
  output pipe_pkg::retire_t  out
);
  import pipe_pkg::*;

  logic  busy_q;      // Read already launched for this load
  logic  start;
  logic  done;
  word_t load_data;

  assign start = in_valid & in.load & ~busy_q;

  always_ff @(posedge clock)
  begin
    if (reset)
      busy_q <= 1'b0;
    else if (start)
      busy_q <= 1'b1;
    else if (done)
      busy_q <= 1'b0;
  end

  bus_txn_fsm i_bus_txn_fsm (
    .clock(clock), .reset(reset), .start(start), .addr(in.load_addr),
    .mem_response(mem_response), .mem_tag(mem_tag), .mem_data(mem_data),
    .command(command), .bus_addr(bus_addr), .done(done), .data(load_data)
  );

  assign stall     = in_valid & in.load & ~done;
  assign out_valid = in_valid & ~stall;       // Bubble downstream while waiting

  // Retire payload
  assign out.npc     = in.npc;
  assign out.halt    = in.halt;
  assign out.illegal = in.illegal;
  assign out.wr_en   = out_valid & in.load & (in.dest != `PIPE_ZERO_REG);
  assign out.dest    = in.dest;
  assign out.wr_data = in.load ? load_data : '0;

endmodule

// ==== hw/fetch_stage.sv ====
// Instruction fetch, one instruction in flight
// Next fetch starts one cycle after the previous one retires
// Stops for good once the halt status is latched, until reset
`timescale 1ns/1ps
`include "pipe_params.svh"

module fetch_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               retire,
  input  logic               halted,
  input  pipe_pkg::tag_t     mem_response,
  input  pipe_pkg::tag_t     mem_tag,
  input  pipe_pkg::word_t    mem_data,
  output pipe_pkg::bus_cmd_t command,
  output pipe_pkg::word_t    bus_addr,
  output logic               fetch_valid,
  output pipe_pkg::fetch_t   fetch
);
  import pipe_pkg::*;

  word_t pc;
  word_t line;        // Whole bus word holding two instructions
  logic  go_q;        // Fetch due once the pipeline drains
  logic  start;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc   <= '0;
      go_q <= 1'b1;                        // First fetch right after reset
    end
    else
    begin
      go_q <= retire;
      if (retire)
        pc <= pc + `PIPE_INST_BYTES;
    end
  end

  // Halt status has latched by the time go_q is up
  assign start = go_q & ~halted;

  bus_txn_fsm i_bus_txn_fsm (
    .clock(clock), .reset(reset), .start(start),
    .addr({pc[`PIPE_XLEN-1:3], 3'b000}),  // Word aligned
    .mem_response(mem_response), .mem_tag(mem_tag), .mem_data(mem_data),
    .command(command), .bus_addr(bus_addr), .done(fetch_valid), .data(line)
  );

  assign fetch.npc  = pc + `PIPE_INST_BYTES;
  assign fetch.inst = !fetch_valid ? `PIPE_NOOP_INST
                    : pc[2]        ? line[63:32]  // Upper half
                                   : line[31:0];

endmodule

// ==== hw/bus_txn_fsm.sv ====
// One split-transaction bus read at a time
// Request held until a nonzero response tag, data taken on matching mem_tag
// done pulses one cycle after the data cycle; start is ignored while busy
// Caller supplies an 8-byte aligned address
`timescale 1ns/1ps

module bus_txn_fsm (
  input  logic               clock,
  input  logic               reset,
  input  logic               start,
  input  pipe_pkg::word_t    addr,
  input  pipe_pkg::tag_t     mem_response,
  input  pipe_pkg::tag_t     mem_tag,
  input  pipe_pkg::word_t    mem_data,
  output pipe_pkg::bus_cmd_t command,
  output pipe_pkg::word_t    bus_addr,
  output logic               done,
  output pipe_pkg::word_t    data
);
  import pipe_pkg::*;

  typedef enum logic [1:0] {IDLE, REQUEST, WAIT_DATA} state_t;

  state_t state;
  word_t  addr_q;     // Held for the whole request phase
  tag_t   tag_q;      // Tag memory gave us on acceptance
  logic   data_hit;

  assign data_hit = (state == WAIT_DATA) && (mem_tag == tag_q);

  ////////////////////////////////////////////////////////////
  // Control
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state <= IDLE;
      tag_q <= '0;
      done  <= 1'b0;
    end
    else
    begin
      done <= data_hit;                       // Single-cycle pulse
      case (state)
        IDLE:
        begin
          if (start)
            state <= REQUEST;                 // Drive the bus from next cycle
        end
        REQUEST:
        begin
          if (mem_response != '0)             // Accepted
          begin
            tag_q <= mem_response;
            state <= WAIT_DATA;
          end
        end
        WAIT_DATA:
        begin
          if (data_hit)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and data
  always_ff @(posedge clock)
  begin
    if (state == IDLE && start)
      addr_q <= addr;
    if (data_hit)
      data <= mem_data;                       // Valid alongside done
  end

  assign command  = (state == REQUEST) ? BUS_LOAD : BUS_NONE;
  assign bus_addr = addr_q;

endmodule

// ==== hw/pipe_reg.sv ====
// Pipeline register with valid bit and hold enable
// Reset clears valid and zeroes the payload, giving a bubble
// Payload type is set per instance
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     enable,      // Low holds the current contents
  input  logic     valid_in,
  input  payload_t data_in,
  output logic     valid_out,
  output payload_t data_out
);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      valid_out <= 1'b0;        // Bubble
      data_out  <= '0;
    end
    else if (enable)
    begin
      valid_out <= valid_in;
      data_out  <= data_in;
    end
  end

endmodule

// ==== hw/inst_decoder.sv ====
// Combinational decode of one instruction
// Recognizes halt, no-op and ldq; every other valid opcode is illegal
// Load address is the displacement only, no base register
`timescale 1ns/1ps
`include "pipe_params.svh"

module inst_decoder (
  input  pipe_pkg::inst_t    inst,
  input  logic               inst_valid,
  output logic               load,
  output logic               halt,
  output logic               illegal,
  output pipe_pkg::reg_idx_t dest_idx,
  output pipe_pkg::word_t    load_addr
);

  logic [5:0] opcode;

  assign opcode   = inst[31:26];
  assign dest_idx = inst[25:21];                       // Ra field
  // Zero-extended disp, forced to a bus word boundary
  assign load_addr = {{(`PIPE_XLEN-16){1'b0}}, inst[15:3], 3'b000};

  always_comb
  begin
    load    = 1'b0;
    halt    = 1'b0;
    illegal = 1'b0;
    if (inst_valid)                                    // Bubbles raise nothing
    begin
      case (opcode)
        `PIPE_OP_HALT: halt = 1'b1;
        `PIPE_OP_NOP:  ;                               // Passes through quietly
        `PIPE_OP_LDQ:  load = 1'b1;
        default:       illegal = 1'b1;
      endcase
    end
  end

endmodule

// ==== hw/pipe_pkg.sv ====
// Types shared by the pipeline stages and the testbench
// Payload structs are packed; field order fixes the bit layout
// Widths follow the params header
`include "pipe_params.svh"

package pipe_pkg;

  typedef logic [`PIPE_XLEN-1:0]      word_t;     // Bus data and address
  typedef logic [`PIPE_INST_W-1:0]    inst_t;
  typedef logic [`PIPE_TAG_W-1:0]     tag_t;      // Zero = not accepted
  typedef logic [`PIPE_REG_IDX_W-1:0] reg_idx_t;

  typedef enum logic [1:0] {BUS_NONE = 2'h0, BUS_LOAD = 2'h1} bus_cmd_t;

  typedef enum logic [3:0]
  {
    NO_ERROR          = 4'h0,
    HALTED_ON_HALT    = 4'h1,
    HALTED_ON_ILLEGAL = 4'h2
  } error_t;

  ////////////////////////////////////////////////////////////
  // Pipeline register payloads

  // IF/ID payload of 96 bits
  typedef struct packed {word_t npc; inst_t inst;} fetch_t;

  // ID/MEM payload of 136 bits
  typedef struct packed
  {
    word_t    npc;
    logic     load;
    logic     halt;
    logic     illegal;
    reg_idx_t dest;
    word_t    load_addr;
  } decoded_t;

  // MEM/WB payload of 136 bits
  typedef struct packed
  {
    word_t    npc;
    logic     halt;
    logic     illegal;
    logic     wr_en;
    reg_idx_t dest;
    word_t    wr_data;
  } retire_t;

endpackage

// ==== hw/pipe_params.svh ====
// Widths and encodings shared by the reduced pipeline
// Opcode sits in bits 31..26; only halt, no-op and ldq decode as legal
// Two 32-bit instructions per 64-bit bus word, PC steps by 4
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

////////////////////////////////////////////////////////////
// Widths
`define PIPE_XLEN       64
`define PIPE_INST_W     32
`define PIPE_TAG_W      4               // Tag 0 means not accepted
`define PIPE_REG_IDX_W  5

`define PIPE_ZERO_REG   5'd31           // Writes here are dropped
`define PIPE_NOOP_INST  32'h47ff041f    // What bubbles carry

////////////////////////////////////////////////////////////
// Opcodes in the top 6 bits
`define PIPE_OP_HALT    6'h00
`define PIPE_OP_NOP     6'h11
`define PIPE_OP_LDQ     6'h29

`define PIPE_INST_BYTES 4               // PC step per instruction
`endif
